/* filelist.f */
+incdir+src
src/fetchPkg.sv
src/preDecode.sv
src/btbValidate.sv
src/ctiQueue.sv
src/fetchStage2.sv
bench/fetchChecker.sv
bench/tbFetchStage2.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tbFetchStage2
FILELIST = filelist.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/tbFetchStage2.sv */
// ----------------------------------------------------------------------
// fetch stage 2 testbench
// random bundles with resolve, commit and recovery traffic
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "fetchCfg.svh"

module tbFetchStage2;
  import fetchPkg::*;

  logic         clk, arstN, fs1Ready, stall, recoverFlag, flagRecoverEX, ctrlVerified;
  logic         branchOutcome, commitCti;
  logic [127:0] bundle;
  pcT           pc, rasAddr, targetAddr, targetAddrID, callPCID, updatePC, updateTarget;
  pcT           btbTarget [`FETCH_WIDTH];
  slotMaskT     btbHit, prediction, instValid;
  ctiTagT       ctiIndex;
  instPacketT   packets [`FETCH_WIDTH];
  logic         flagRecoverID, flagRtrID, flagCallID, updateEn, updateDir, full, fs2Ready;
  brTypeT       updateType;
  int           failTests, testCount;

  fetchStage2 u_fetchStage2 (
    .clk(clk), .arstN_i(arstN), .fs1Ready_i(fs1Ready), .stall_i(stall),
    .recoverFlag_i(recoverFlag), .pc_i(pc), .instructionBundle_i(bundle),
    .addrRAS_CP_i(rasAddr), .btbHit_i(btbHit), .btbTarget_i(btbTarget),
    .prediction_i(prediction), .ctiQueueIndex_i(ctiIndex), .targetAddr_i(targetAddr),
    .branchOutcome_i(branchOutcome), .flagRecoverEX_i(flagRecoverEX),
    .ctrlVerified_i(ctrlVerified), .commitCti_i(commitCti), .instValid_o(instValid),
    .inst0Packet_o(packets[0]), .inst1Packet_o(packets[1]), .inst2Packet_o(packets[2]),
    .inst3Packet_o(packets[3]), .flagRecoverID_o(flagRecoverID),
    .targetAddrID_o(targetAddrID), .flagRtrID_o(flagRtrID), .flagCallID_o(flagCallID),
    .callPCID_o(callPCID), .updatePC_o(updatePC), .updateTargetAddr_o(updateTarget),
    .updateCtrlType_o(updateType), .updateDir_o(updateDir), .updateEn_o(updateEn),
    .fs2Ready_o(fs2Ready), .ctiQueueFull_o(full)
  );

  fetchChecker u_checker (
    .clk(clk), .arstN_i(arstN), .fs1Ready_i(fs1Ready), .stall_i(stall),
    .recoverFlag_i(recoverFlag), .flagRecoverEX_i(flagRecoverEX),
    .ctrlVerified_i(ctrlVerified), .branchOutcome_i(branchOutcome), .commitCti_i(commitCti),
    .pc_i(pc), .addrRAS_CP_i(rasAddr), .targetAddr_i(targetAddr), .bundle_i(bundle),
    .btbTarget_i(btbTarget), .btbHit_i(btbHit), .prediction_i(prediction),
    .instValid_i(instValid), .ctiQueueIndex_i(ctiIndex), .packets_i(packets),
    .flagRecoverID_i(flagRecoverID), .flagRtrID_i(flagRtrID), .flagCallID_i(flagCallID),
    .updateEn_i(updateEn), .updateDir_i(updateDir), .full_i(full), .fs2Ready_i(fs2Ready),
    .targetAddrID_i(targetAddrID), .callPCID_i(callPCID), .updatePC_i(updatePC),
    .updateTargetAddr_i(updateTarget), .updateCtrlType_i(updateType)
  );

  always #20 clk = ~clk;

  // drives one cycle of traffic where each percentage sets how often its event fires
  task automatic driveCycle(input logic fetchOn, input int resPct, exPct, flushPct, cmPct);
    logic [127:0] bund;
    pcT           pcV;
    logic [15:0]  off;
    logic [5:0]   op;
    pcT           tgt;
    @(posedge clk);
    pcV = $urandom & 32'hFFFF_FFF0;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      case ($urandom % 6)
        0: op = OP_BEQ;
        1: op = OP_J;
        2: op = OP_JAL;
        3: op = OP_JR31;
        default: op = 6'h20 + 6'($urandom % 8);  // plain ALU filler
      endcase
      off = 16'($urandom % 64) - 16'd32;
      bund[i*32 +: 32] = {op, 10'($urandom), off};
      tgt = pcV + pcT'(4 * i + 4) + {{14{off[15]}}, off, 2'b00};
      btbTarget[i] <= ($urandom % 4 == 0) ? pcT'($urandom) : tgt;
    end
    bundle <= bund;
    pc <= pcV;
    rasAddr <= $urandom;
    btbHit <= 4'($urandom);
    prediction <= 4'($urandom);
    stall <= ($urandom % 4 == 0);
    fs1Ready <= fetchOn & ($urandom % 8 != 0);
    targetAddr <= $urandom;
    branchOutcome <= 1'($urandom);
    commitCti <= ($urandom % 100 < cmPct);
    recoverFlag <= ($urandom % 100 < flushPct);
    ctiIndex <= u_checker.headM;
    ctrlVerified <= 1'b0;
    flagRecoverEX <= 1'b0;
    if (u_checker.countM > 0) begin
      ctiIndex <= u_checker.headM + ctiTagT'($urandom % u_checker.countM);  // a live entry
      ctrlVerified <= ($urandom % 100 < resPct);
      flagRecoverEX <= ($urandom % 100 < exPct);
    end
  endtask

  task automatic runTest(input string name, input int cycles, resPct, exPct, flushPct, cmPct);
    int errBefore;
    errBefore = u_checker.errCount;
    repeat (cycles) driveCycle(1'b1, resPct, exPct, flushPct, cmPct);
    testCount++;
    if (u_checker.errCount != errBefore) failTests++;
    $display("test %s: %0d mismatches", name, u_checker.errCount - errBefore);
  endtask

  initial begin
    int waitCnt;
    void'($urandom(63349));
    {clk, arstN, fs1Ready, stall, recoverFlag, flagRecoverEX, ctrlVerified} = '0;
    {branchOutcome, commitCti, bundle, pc, rasAddr, targetAddr} = '0;
    {btbHit, prediction, ctiIndex, failTests, testCount} = '0;
    for (int i = 0; i < `FETCH_WIDTH; i++) btbTarget[i] = '0;
    repeat (10) @(posedge clk);
    arstN <= 1'b1;
    runTest("bundles and fill", 60, 0, 0, 0, 0);
    runTest("resolve and commit", 300, 60, 0, 0, 50);
    runTest("execute recovery", 300, 50, 10, 0, 50);
    runTest("full flush", 300, 50, 5, 5, 50);
    waitCnt = 0;
    while (u_checker.countM != 0 && waitCnt < 200) begin  // drain with fetch off
      driveCycle(1'b0, 100, 0, 0, 100);
      waitCnt++;
    end
    if (u_checker.countM != 0) begin
      $display("drain timed out, the CTI queue never emptied");
      $display("TB FAILED");
      $finish;
    end
    repeat (2) driveCycle(1'b0, 0, 0, 0, 0);
    $display("tests %0d, failed %0d, checks %0d, mismatches %0d", testCount, failTests,
             u_checker.checkCount, u_checker.errCount);
    if (failTests == 0 && u_checker.errCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* bench/fetchChecker.sv */
// ----------------------------------------------------------------------
// fetch stage 2 checker
// reference model of the bundle logic and the CTI queue, compared
// against the DUT on every falling clock edge
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "fetchCfg.svh"

module fetchChecker (
  input logic                 clk, arstN_i, fs1Ready_i, stall_i, recoverFlag_i,
  input logic                 flagRecoverEX_i, ctrlVerified_i, branchOutcome_i, commitCti_i,
  input fetchPkg::pcT         pc_i, addrRAS_CP_i, targetAddr_i,
  input logic [127:0]         bundle_i,
  input fetchPkg::pcT         btbTarget_i [`FETCH_WIDTH],
  input fetchPkg::slotMaskT   btbHit_i, prediction_i, instValid_i,
  input fetchPkg::ctiTagT     ctiQueueIndex_i,
  input fetchPkg::instPacketT packets_i [`FETCH_WIDTH],
  input logic                 flagRecoverID_i, flagRtrID_i, flagCallID_i,
  input logic                 updateEn_i, updateDir_i, full_i, fs2Ready_i,
  input fetchPkg::pcT         targetAddrID_i, callPCID_i, updatePC_i, updateTargetAddr_i,
  input fetchPkg::brTypeT     updateCtrlType_i
);
  import fetchPkg::*;

  int errCount = 0;
  int checkCount = 0;

  // queue model state as it will be after the next rising edge
  ctiTagT headM, tailM;
  int     countM;
  pcT     pcM [`CTIQ_DEPTH];
  pcT     tgtM [`CTIQ_DEPTH];
  brTypeT typM [`CTIQ_DEPTH];
  logic   dirM [`CTIQ_DEPTH];
  logic   resM [`CTIQ_DEPTH];
  logic   pendEn, pendDir;
  pcT     pendPc, pendTgt;
  brTypeT pendTyp;

  function automatic void refBundle(input logic [127:0] bundle, input pcT pc0, ras,
      input slotMaskT hit, pred, input pcT btbT [`FETCH_WIDTH], input logic stallIn, fullIn,
      output slotMaskT valid, alloc, output logic [127:0] tgts, output logic rec, rtr, call,
      output pcT kTgt, kPc, output brTypeT types [`FETCH_WIDTH]);
    instT   ins;
    pcT     pcS;
    pcT     tgt;
    brTypeT ty;
    logic   ctrl;
    logic   found;
    logic   miss;
    found = 0;
    valid = '1;
    alloc = '0;
    {rec, rtr, call} = 3'b000;
    kTgt = '0;
    kPc = '0;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      ins = bundle[i*32 +: 32];
      pcS = pc0 + pcT'(4 * i);
      ctrl = 1'b1;
      case (ins[31:26])
        OP_BEQ:  ty = BR_COND;
        OP_J:    ty = BR_JUMP;
        OP_JAL:  ty = BR_CALL;
        OP_JR31: ty = BR_RETURN;
        default: begin
          ctrl = 1'b0;
          ty = BR_JUMP;
        end
      endcase
      types[i] = ty;
      tgt = (ctrl && ty == BR_RETURN) ? '0 : pcS + 4 + {{14{ins[15]}}, ins[15:0], 2'b00};
      if (!found && ctrl && (ty != BR_COND || pred[i])) begin
        found = 1'b1;
        if (ty == BR_RETURN) tgt = ras;  // return address comes from the RAS
        kTgt = tgt;
        kPc = pcS;
        alloc[i] = 1'b1;
        valid = slotMaskT'((1 << (i + 1)) - 1);
        miss = ~hit[i] | (ty != BR_RETURN && btbT[i] != tgt);
        rec = miss & ~stallIn & ~fullIn;
        rtr = miss & (ty == BR_RETURN);
        call = miss & (ty == BR_CALL);
      end else if (!found && ctrl && ty == BR_COND) begin
        alloc[i] = 1'b1;  // not-taken branch still needs a queue entry
      end
      tgts[i*32 +: 32] = tgt;
    end
  endfunction

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  always @(negedge clk) begin : compare
    slotMaskT     valid, alloc;
    logic [127:0] tgts;
    logic         rec, rtr, call, full, allocEn, pop, nEn;
    pcT           kTgt, kPc;
    brTypeT       types [`FETCH_WIDTH];
    ctiTagT       t;
    int           ofs;
    if (!arstN_i) begin
      headM = '0;
      tailM = '0;
      countM = 0;
      pendEn = 1'b0;
      for (int j = 0; j < `CTIQ_DEPTH; j++) resM[j] = 1'b0;
    end else begin
      full = countM > (`CTIQ_DEPTH - `FETCH_WIDTH);
      refBundle(bundle_i, pc_i, addrRAS_CP_i, btbHit_i, prediction_i, btbTarget_i, stall_i,
                full, valid, alloc, tgts, rec, rtr, call, kTgt, kPc, types);
      checkVal("instValid_o", 32'(instValid_i), 32'(valid));
      checkVal("flagRecoverID_o", 32'(flagRecoverID_i), 32'(rec));
      checkVal("flagRtrID_o", 32'(flagRtrID_i), 32'(rtr));
      checkVal("flagCallID_o", 32'(flagCallID_i), 32'(call));
      checkVal("targetAddrID_o", targetAddrID_i, kTgt);
      checkVal("callPCID_o", callPCID_i, kPc);
      checkVal("ctiQueueFull_o", 32'(full_i), 32'(full));
      checkVal("fs2Ready_o", 32'(fs2Ready_i), 32'(fs1Ready_i & ~full));
      ofs = 0;
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
        checkVal($sformatf("packet%0d.instr", i), packets_i[i][100:69], bundle_i[i*32 +: 32]);
        checkVal($sformatf("packet%0d.pc", i), packets_i[i][68:37], pc_i + pcT'(4 * i));
        checkVal($sformatf("packet%0d.target", i), packets_i[i][36:5], tgts[i*32 +: 32]);
        checkVal($sformatf("packet%0d.tag", i), 32'(packets_i[i][4:1]),
                 32'(ctiTagT'(tailM + ofs)));  // tags wrap with the queue index
        checkVal($sformatf("packet%0d.pred", i), 32'(packets_i[i][0]), 32'(prediction_i[i]));
        ofs += int'(alloc[i]);
      end
      checkVal("updateEn_o", 32'(updateEn_i), 32'(pendEn));
      if (pendEn) begin
        checkVal("updatePC_o", updatePC_i, pendPc);
        checkVal("updateTargetAddr_o", updateTargetAddr_i, pendTgt);
        checkVal("updateCtrlType_o", 32'(updateCtrlType_i), 32'(pendTyp));
        checkVal("updateDir_o", 32'(updateDir_i), 32'(pendDir));
      end
      // step the model over the coming rising edge
      allocEn = fs1Ready_i & ~stall_i & ~full & ~recoverFlag_i & ~flagRecoverEX_i;
      pop = commitCti_i && countM != 0;
      nEn = pop & resM[headM];
      pendPc = pcM[headM];
      pendTgt = tgtM[headM];
      pendTyp = typM[headM];
      pendDir = dirM[headM];
      t = tailM;
      if (allocEn) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
          if (alloc[i]) begin
            pcM[t] = pc_i + pcT'(4 * i);
            tgtM[t] = tgts[i*32 +: 32];
            typM[t] = types[i];
            resM[t] = 1'b0;
            t = t + 1'b1;
          end
        end
      end
      if (ctrlVerified_i) begin
        tgtM[ctiQueueIndex_i] = targetAddr_i;
        dirM[ctiQueueIndex_i] = branchOutcome_i;
        resM[ctiQueueIndex_i] = 1'b1;
      end
      if (recoverFlag_i) begin
        tailM = headM;
        countM = 0;
        pendEn = 1'b0;
      end else begin
        if (flagRecoverEX_i) begin
          countM = int'(ctiTagT'(ctiQueueIndex_i - headM)) + 1 - int'(pop);
          tailM = ctiQueueIndex_i + 1'b1;
        end else begin
          countM = countM + (allocEn ? ofs : 0) - int'(pop);
          tailM = allocEn ? t : tailM;
        end
        headM = headM + ctiTagT'(pop);
        pendEn = nEn;
      end
    end
  end

endmodule

/* src/fetchStage2.sv */
// ----------------------------------------------------------------------
// fetch stage 2 of the four-wide front end
// splits the bundle, pre-decodes each slot, validates the BTB lookups
// and tags control transfers in the CTI queue
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "fetchCfg.svh"

module fetchStage2 (
  input  logic                              clk,
  input  logic                              arstN_i,
  input  logic                              fs1Ready_i,
  input  logic                              stall_i,
  input  logic                              recoverFlag_i,
  input  fetchPkg::pcT                      pc_i,
  input  logic [`FETCH_WIDTH*`SIZE_INST-1:0] instructionBundle_i,
  input  fetchPkg::pcT                      addrRAS_CP_i,
  input  fetchPkg::slotMaskT                btbHit_i,
  input  fetchPkg::pcT                      btbTarget_i [`FETCH_WIDTH],
  input  fetchPkg::slotMaskT                prediction_i,
  input  fetchPkg::ctiTagT                  ctiQueueIndex_i,
  input  fetchPkg::pcT                      targetAddr_i,
  input  logic                              branchOutcome_i,
  input  logic                              flagRecoverEX_i,
  input  logic                              ctrlVerified_i,
  input  logic [`RETIRE_WIDTH-1:0]          commitCti_i,
  output fetchPkg::slotMaskT                instValid_o,
  output fetchPkg::instPacketT              inst0Packet_o,
  output fetchPkg::instPacketT              inst1Packet_o,
  output fetchPkg::instPacketT              inst2Packet_o,
  output fetchPkg::instPacketT              inst3Packet_o,
  output logic                              flagRecoverID_o,
  output fetchPkg::pcT                      targetAddrID_o,
  output logic                              flagRtrID_o,
  output logic                              flagCallID_o,
  output fetchPkg::pcT                      callPCID_o,
  output fetchPkg::pcT                      updatePC_o,
  output fetchPkg::pcT                      updateTargetAddr_o,
  output fetchPkg::brTypeT                  updateCtrlType_o,
  output logic                              updateDir_o,
  output logic                              updateEn_o,
  output logic                              fs2Ready_o,
  output logic                              ctiQueueFull_o
);
  import fetchPkg::*;

  instT       instr      [`FETCH_WIDTH];
  pcT         slotPc     [`FETCH_WIDTH];
  brTypeT     brType     [`FETCH_WIDTH];
  pcT         decTarget  [`FETCH_WIDTH];
  pcT         slotTarget [`FETCH_WIDTH];
  ctiTagT     tag        [`FETCH_WIDTH];
  instPacketT packet     [`FETCH_WIDTH];
  slotMaskT   isCtrl;
  slotMaskT   allocMask;

  for (genvar i = 0; i < `FETCH_WIDTH; i++) begin : gSlot
    assign instr[i]  = instructionBundle_i[i*`SIZE_INST +: `SIZE_INST];  // slot 0 in the low word
    assign slotPc[i] = pc_i + pcT'(i * `INST_BYTES);

    preDecode u_preDecode (
      .instr_i  (instr[i]),
      .pc_i     (slotPc[i]),
      .isCtrl_o (isCtrl[i]),
      .brType_o (brType[i]),
      .target_o (decTarget[i])
    );

    assign packet[i] = {instr[i], slotPc[i], slotTarget[i], tag[i], prediction_i[i]};
  end

  assign inst0Packet_o = packet[0];
  assign inst1Packet_o = packet[1];
  assign inst2Packet_o = packet[2];
  assign inst3Packet_o = packet[3];

  btbValidate u_btbValidate (
    .isCtrl_i        (isCtrl),
    .brType_i        (brType),
    .decTarget_i     (decTarget),
    .pc_i            (slotPc),
    .prediction_i    (prediction_i),
    .btbHit_i        (btbHit_i),
    .btbTarget_i     (btbTarget_i),
    .rasAddr_i       (addrRAS_CP_i),
    .stall_i         (stall_i),
    .ctiQueueFull_i  (ctiQueueFull_o),
    .instValid_o     (instValid_o),
    .allocMask_o     (allocMask),
    .slotTarget_o    (slotTarget),
    .flagRecoverID_o (flagRecoverID_o),
    .flagRtrID_o     (flagRtrID_o),
    .flagCallID_o    (flagCallID_o),
    .targetAddrID_o  (targetAddrID_o),
    .callPCID_o      (callPCID_o)
  );

  ctiQueue u_ctiQueue (
    .clk                (clk),
    .arstN_i            (arstN_i),
    .fs1Ready_i         (fs1Ready_i),
    .stall_i            (stall_i),
    .recoverFlag_i      (recoverFlag_i),
    .allocMask_i        (allocMask),
    .pc_i               (slotPc),
    .brType_i           (brType),
    .target_i           (slotTarget),
    .ctiQueueIndex_i    (ctiQueueIndex_i),
    .targetAddr_i       (targetAddr_i),
    .branchOutcome_i    (branchOutcome_i),
    .flagRecoverEX_i    (flagRecoverEX_i),
    .ctrlVerified_i     (ctrlVerified_i),
    .commitCti_i        (commitCti_i),
    .tag_o              (tag),
    .ctiQueueFull_o     (ctiQueueFull_o),
    .fs2Ready_o         (fs2Ready_o),
    .updatePC_o         (updatePC_o),
    .updateTargetAddr_o (updateTargetAddr_o),
    .updateCtrlType_o   (updateCtrlType_o),
    .updateDir_o        (updateDir_o),
    .updateEn_o         (updateEn_o)
  );

endmodule

/* src/ctiQueue.sv */
// ----------------------------------------------------------------------
// control transfer queue
// tags in-flight transfers in fetch order, takes their execute results
// out of order and sends one predictor update per committed transfer
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "fetchCfg.svh"

module ctiQueue (
  input  logic                     clk,
  input  logic                     arstN_i,
  input  logic                     fs1Ready_i,
  input  logic                     stall_i,
  input  logic                     recoverFlag_i,
  input  fetchPkg::slotMaskT       allocMask_i,
  input  fetchPkg::pcT             pc_i     [`FETCH_WIDTH],
  input  fetchPkg::brTypeT         brType_i [`FETCH_WIDTH],
  input  fetchPkg::pcT             target_i [`FETCH_WIDTH],
  input  fetchPkg::ctiTagT         ctiQueueIndex_i,
  input  fetchPkg::pcT             targetAddr_i,
  input  logic                     branchOutcome_i,
  input  logic                     flagRecoverEX_i,
  input  logic                     ctrlVerified_i,
  input  logic [`RETIRE_WIDTH-1:0] commitCti_i,
  output fetchPkg::ctiTagT         tag_o [`FETCH_WIDTH],
  output logic                     ctiQueueFull_o,
  output logic                     fs2Ready_o,
  output fetchPkg::pcT             updatePC_o,
  output fetchPkg::pcT             updateTargetAddr_o,
  output fetchPkg::brTypeT         updateCtrlType_o,
  output logic                     updateDir_o,
  output logic                     updateEn_o
);
  import fetchPkg::*;

  localparam int CntW  = `CTIQ_LOG + 1;
  localparam int SlotW = $clog2(`FETCH_WIDTH);

  pcT                     pcQ     [`CTIQ_DEPTH];
  pcT                     targetQ [`CTIQ_DEPTH];
  brTypeT                 typeQ   [`CTIQ_DEPTH];
  logic [`CTIQ_DEPTH-1:0] dirQ;
  logic [`CTIQ_DEPTH-1:0] resolvedQ;

  ctiTagT           headQ;
  ctiTagT           tailQ;
  ctiTagT           runTag;
  logic [CntW-1:0]  countQ;
  logic [CntW-1:0]  countNext;
  logic [CntW-1:0]  liveCnt;
  logic [SlotW:0]   allocNum;
  logic             allocEn;
  logic             pop;

  // tags run on from the tail over the slots that allocate
  always_comb begin
    runTag   = tailQ;
    allocNum = '0;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      tag_o[i] = runTag;
      if (allocMask_i[i]) begin
        runTag   = runTag + 1'b1;
        allocNum = allocNum + 1'b1;
      end
    end
  end

  // room for a whole bundle is needed before anything is taken in
  assign ctiQueueFull_o = countQ > CntW'(`CTIQ_DEPTH - `FETCH_WIDTH);
  assign fs2Ready_o     = fs1Ready_i & ~ctiQueueFull_o;

  // the bundle seen during an execute recovery is wrong path
  assign allocEn = fs1Ready_i & ~stall_i & ~ctiQueueFull_o & ~recoverFlag_i & ~flagRecoverEX_i;
  assign pop     = commitCti_i[0] & (countQ != '0);

  // head up to and including the mispredicted transfer survives
  assign liveCnt = CntW'(ctiTagT'(ctiQueueIndex_i - headQ)) + 1'b1;

  always_comb begin
    if (flagRecoverEX_i) begin
      countNext = liveCnt - CntW'(pop);
    end else if (allocEn) begin
      countNext = countQ + CntW'(allocNum) - CntW'(pop);
    end else begin
      countNext = countQ - CntW'(pop);
    end
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      headQ      <= '0;
      tailQ      <= '0;
      countQ     <= '0;
      updateEn_o <= 1'b0;
    end else if (recoverFlag_i) begin
      tailQ      <= headQ;  // full flush, a commit in this cycle is lost too
      countQ     <= '0;
      updateEn_o <= 1'b0;
    end else begin
      if (pop) begin
        headQ <= headQ + 1'b1;
      end
      if (flagRecoverEX_i) begin
        tailQ <= ctiQueueIndex_i + 1'b1;
      end else if (allocEn) begin
        tailQ <= tailQ + ctiTagT'(allocNum);
      end
      countQ     <= countNext;
      updateEn_o <= pop & resolvedQ[headQ];  // unresolved entries teach the predictor nothing
    end
  end

  always_ff @(posedge clk) begin
    if (allocEn) begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
        if (allocMask_i[i]) begin
          pcQ[tag_o[i]]       <= pc_i[i];
          typeQ[tag_o[i]]     <= brType_i[i];
          targetQ[tag_o[i]]   <= target_i[i];
          resolvedQ[tag_o[i]] <= 1'b0;
        end
      end
    end
    // execute result, applied even when the tail is cut back
    if (ctrlVerified_i) begin
      targetQ[ctiQueueIndex_i]   <= targetAddr_i;
      dirQ[ctiQueueIndex_i]      <= branchOutcome_i;
      resolvedQ[ctiQueueIndex_i] <= 1'b1;
    end
    if (pop) begin
      updatePC_o         <= pcQ[headQ];
      updateTargetAddr_o <= targetQ[headQ];
      updateCtrlType_o   <= typeQ[headQ];
      updateDir_o        <= dirQ[headQ];
    end
  end

endmodule

/* src/btbValidate.sv */
// ----------------------------------------------------------------------
// BTB validation for one fetch bundle
// finds the first redirecting transfer, filters the younger slots,
// picks the CTI queue allocations and raises a decode-time redirect
// when the BTB did not foresee the transfer
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "fetchCfg.svh"

module btbValidate (
  input  fetchPkg::slotMaskT isCtrl_i,
  input  fetchPkg::brTypeT   brType_i    [`FETCH_WIDTH],
  input  fetchPkg::pcT       decTarget_i [`FETCH_WIDTH],
  input  fetchPkg::pcT       pc_i        [`FETCH_WIDTH],
  input  fetchPkg::slotMaskT prediction_i,
  input  fetchPkg::slotMaskT btbHit_i,
  input  fetchPkg::pcT       btbTarget_i [`FETCH_WIDTH],
  input  fetchPkg::pcT       rasAddr_i,
  input  logic               stall_i,
  input  logic               ctiQueueFull_i,
  output fetchPkg::slotMaskT instValid_o,
  output fetchPkg::slotMaskT allocMask_o,
  output fetchPkg::pcT       slotTarget_o [`FETCH_WIDTH],
  output logic               flagRecoverID_o,
  output logic               flagRtrID_o,
  output logic               flagCallID_o,
  output fetchPkg::pcT       targetAddrID_o,
  output fetchPkg::pcT       callPCID_o
);
  import fetchPkg::*;

  localparam int SlotW = $clog2(`FETCH_WIDTH);

  slotMaskT         redirect;
  slotMaskT         notTaken;
  logic             found;
  logic [SlotW-1:0] kIdx;
  brTypeT           kType;
  pcT               kTarget;
  logic             kMiss;

  // everything but a not-taken conditional moves fetch away
  always_comb begin
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      notTaken[i] = isCtrl_i[i] & (brType_i[i] == BR_COND) & ~prediction_i[i];
      redirect[i] = isCtrl_i[i] & ((brType_i[i] != BR_COND) | prediction_i[i]);
    end
  end

  // searching downwards leaves the oldest redirecting slot in kIdx
  always_comb begin
    found = 1'b0;
    kIdx  = '0;
    for (int i = `FETCH_WIDTH-1; i >= 0; i--) begin
      if (redirect[i]) begin
        found = 1'b1;
        kIdx  = SlotW'(i);
      end
    end
  end

  assign kType   = brType_i[kIdx];
  assign kTarget = (kType == BR_RETURN) ? rasAddr_i : decTarget_i[kIdx];

  // a hit only counts when the BTB target agrees with the decoded one
  // returns are left out, their target comes from the RAS anyway
  assign kMiss = found & (~btbHit_i[kIdx] |
                          ((kType != BR_RETURN) && (btbTarget_i[kIdx] != kTarget)));

  always_comb begin
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      instValid_o[i]  = ~found | (SlotW'(i) <= kIdx);
      allocMask_o[i]  = (notTaken[i] & (~found | (SlotW'(i) < kIdx))) |
                        (found & (SlotW'(i) == kIdx));
      slotTarget_o[i] = (found && SlotW'(i) == kIdx) ? kTarget : decTarget_i[i];
    end
  end

  assign targetAddrID_o = found ? kTarget : '0;
  assign callPCID_o     = found ? pc_i[kIdx] : '0;  // return address base for the RAS push

  // no redirect while the bundle cannot move on
  assign flagRecoverID_o = kMiss & ~stall_i & ~ctiQueueFull_i;
  assign flagRtrID_o     = kMiss & (kType == BR_RETURN);
  assign flagCallID_o    = kMiss & (kType == BR_CALL);

endmodule

/* src/preDecode.sv */
// ----------------------------------------------------------------------
// pre-decoder for one fetch slot
// spots control transfers, gives their kind and the direct target
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "fetchCfg.svh"

module preDecode (
  input  fetchPkg::instT   instr_i,
  input  fetchPkg::pcT     pc_i,
  output logic             isCtrl_o,
  output fetchPkg::brTypeT brType_o,
  output fetchPkg::pcT     target_o
);
  import fetchPkg::*;

  opcodeT opcode;
  pcT     offset;
  pcT     directTarget;

  assign opcode = instr_i[31:26];

  // word offset in bits 15:0, sign extended and scaled to bytes
  assign offset = {{(`SIZE_PC-18){instr_i[15]}}, instr_i[15:0], 2'b00};

  assign directTarget = pc_i + pcT'(`INST_BYTES) + offset;  // relative to the next slot

  always_comb begin
    isCtrl_o = 1'b1;
    brType_o = BR_JUMP;
    case (opcode)
      OP_BEQ:  brType_o = BR_COND;
      OP_J:    brType_o = BR_JUMP;
      OP_JAL:  brType_o = BR_CALL;
      OP_JR31: brType_o = BR_RETURN;
      default: begin
        isCtrl_o = 1'b0;  // plain instruction, kind is don't care
        brType_o = BR_JUMP;
      end
    endcase
  end

  // a return has no encoded target, the RAS address is put in later
  assign target_o = (isCtrl_o && brType_o == BR_RETURN) ? '0 : directTarget;

endmodule

/* src/fetchPkg.sv */
// ----------------------------------------------------------------------
// fetch stage 2 types
// vector typedefs, branch kinds and opcodes of the small ISA
// ----------------------------------------------------------------------
`include "fetchCfg.svh"

package fetchPkg;

  typedef logic [`SIZE_PC-1:0]     pcT;
  typedef logic [`SIZE_INST-1:0]   instT;
  typedef logic [`CTIQ_LOG-1:0]    ctiTagT;
  typedef logic [1:0]              brTypeT;
  typedef logic [`FETCH_WIDTH-1:0] slotMaskT;  // bit 0 is slot 0
  typedef logic [5:0]              opcodeT;

  // instruction, pc, target, queue tag and predicted direction, msb first
  typedef logic [`SIZE_INST+2*`SIZE_PC+`CTIQ_LOG:0] instPacketT;

  // control kinds as the predictor sees them
  localparam brTypeT BR_RETURN = 2'b00;
  localparam brTypeT BR_CALL   = 2'b01;
  localparam brTypeT BR_JUMP   = 2'b10;
  localparam brTypeT BR_COND   = 2'b11;

  // opcodes live in bits 31:26
  localparam opcodeT OP_J    = 6'h02;
  localparam opcodeT OP_JAL  = 6'h03;
  localparam opcodeT OP_BEQ  = 6'h04;
  localparam opcodeT OP_JR31 = 6'h08;   // jump register through r31, a return

endpackage

/* src/fetchCfg.svh */
// ----------------------------------------------------------------------
// fetch stage 2 configuration
// bundle width, datapath widths and CTI queue sizing
// ----------------------------------------------------------------------
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// front end geometry
`define FETCH_WIDTH   4   // slots per fetch bundle
`define INST_BYTES    4   // pc step from one slot to the next

// datapath widths
`define SIZE_PC       32
`define SIZE_INST     32

// control transfer queue, depth must stay a power of two
`define CTIQ_DEPTH    16
`define CTIQ_LOG      4

// only one transfer commits per cycle
`define RETIRE_WIDTH  1

`endif
